//--- filelist.f
+incdir+include
verilog/aesPkg.sv
verilog/sbox.sv
verilog/keyExpansion.sv
verilog/aesRoundEngine.sv
verilog/aesRegDecode.sv
verilog/aesResult.sv
verilog/aesCore.sv
test/aesModel.sv
test/aesCore_checker.sv
test/aesCoreTb.sv

//--- include/aes_macros.svh
`ifndef AES_MACROS_SVH
`define AES_MACROS_SVH

`define AES_ROUNDS 10 // AES-128 round count
`define AXI_ADDR_W 6  // byte address into the register map
`define AXI_DATA_W 32

// register byte offsets
`define REG_CTRL   6'h00 // bit 0 starts a job
`define REG_STATUS 6'h04 // bit 0 busy, bit 1 done
`define REG_KEY0   6'h10 // most significant key word
`define REG_KEY1   6'h14
`define REG_KEY2   6'h18
`define REG_KEY3   6'h1C
`define REG_PT0    6'h20 // most significant plaintext word
`define REG_PT1    6'h24
`define REG_PT2    6'h28
`define REG_PT3    6'h2C
`define REG_CT0    6'h30 // most significant ciphertext word
`define REG_CT1    6'h34
`define REG_CT2    6'h38
`define REG_CT3    6'h3C

`endif

//--- run.sh
#!/bin/sh
# build and run the AES core regression with Verilator
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module aesCoreTb \
  && ./obj_dir/VaesCoreTb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Regression passed" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

//--- test/aesCoreTb.sv
`default_nettype none

`include "aes_macros.svh"

module aesCoreTb;
  import aesPkg::*;

  localparam int JOBS           = 20;
  localparam int CYCLES_PER_JOB = 200;
  localparam int MAX_CYCLES     = JOBS * CYCLES_PER_JOB;

  logic        clk;
  logic        reset;
  axiWrReq_s   wrReq;
  axiWrRsp_s   wrRsp;
  axiRdReq_s   rdReq;
  axiRdRsp_s   rdRsp;
  logic [31:0] lfsr;       // random state
  int          cycles = 0;

  aesCore i_aesCore (
    .clk  (clk),
    .reset(reset),
    .wrReq(wrReq),
    .wrRsp(wrRsp),
    .rdReq(rdReq),
    .rdRsp(rdRsp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "run stopped");
  endtask

  task automatic reportMismatch(input string msg);
    $display("[FAIL] time %0t: %s", $time, msg);
    $display("Regression failed");
    $fatal(1, "value mismatch");
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) abortRun("Timeout reached before the tests finished");
  end

  // fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic block128_t randBlock();
    block128_t b;
    for (int i = 0; i < 4; i++) b[127-32*i -: 32] = randBits(32);
    return b;
  endfunction

  function automatic int randDelay();
    return int'(randBits(2)); // 0 to 3 cycles
  endfunction

  // legal write and read addresses of the register map
  function automatic logic isWritable(input regAddr_t a);
    return (a == 6'h00) || (a[1:0] == 2'b00 && a >= 6'h10 && a <= 6'h2C);
  endfunction

  function automatic logic isReadable(input regAddr_t a);
    return (a == 6'h04) || (a[1:0] == 2'b00 && a >= 6'h30);
  endfunction

  task automatic checkBlock(input block128_t got, input block128_t exp, input string what);
    if (got !== exp) reportMismatch($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic checkWord(input word32_t got, input word32_t exp, input string what);
    if (got !== exp) reportMismatch($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic checkResp(input axiResp_t got, input axiResp_t exp, input string what);
    if (got !== exp) reportMismatch($sformatf("%s got resp %0d expected %0d", what, got, exp));
  endtask

  task automatic busWrite(input regAddr_t addr, input word32_t data, input logic [3:0] strb,
                          input int delay, output axiResp_t resp);
    axiResp_t firstResp;
    @(posedge clk);
    wrReq.awaddr  <= addr;
    wrReq.wdata   <= data;
    wrReq.wstrb   <= strb;
    wrReq.awvalid <= 1'b1;
    wrReq.wvalid  <= 1'b1;
    @(negedge clk);
    while (!wrRsp.awready) @(negedge clk);
    if (!wrRsp.wready) abortRun("wready did not rise together with awready");
    @(posedge clk);
    wrReq.awvalid <= 1'b0;
    wrReq.wvalid  <= 1'b0;
    @(negedge clk);
    if (!wrRsp.bvalid) abortRun("bvalid did not rise after the write handshake");
    firstResp = wrRsp.bresp;
    repeat (delay) begin // bready held back
      @(negedge clk);
      if (!wrRsp.bvalid) abortRun("bvalid dropped before bready");
      checkResp(wrRsp.bresp, firstResp, "bresp while waiting");
    end
    @(posedge clk);
    wrReq.bready <= 1'b1;
    @(negedge clk);
    if (!wrRsp.bvalid) abortRun("bvalid dropped before bready");
    @(posedge clk);
    wrReq.bready <= 1'b0;
    resp = firstResp;
  endtask

  task automatic busRead(input regAddr_t addr, input int delay,
                         output word32_t data, output axiResp_t resp);
    @(posedge clk);
    rdReq.araddr  <= addr;
    rdReq.arvalid <= 1'b1;
    @(negedge clk);
    while (!rdRsp.arready) @(negedge clk);
    @(posedge clk);
    rdReq.arvalid <= 1'b0;
    @(negedge clk);
    if (!rdRsp.rvalid) abortRun("rvalid did not rise after the read handshake");
    data = rdRsp.rdata;
    resp = rdRsp.rresp;
    repeat (delay) begin
      @(negedge clk);
      if (!rdRsp.rvalid) abortRun("rvalid dropped before rready");
      checkWord(rdRsp.rdata, data, "rdata while waiting");
      checkResp(rdRsp.rresp, resp, "rresp while waiting");
    end
    @(posedge clk);
    rdReq.rready <= 1'b1;
    @(negedge clk);
    if (!rdRsp.rvalid) abortRun("rvalid dropped before rready");
    @(posedge clk);
    rdReq.rready <= 1'b0;
  endtask

  task automatic writeExpect(input regAddr_t addr, input word32_t data, input logic [3:0] strb,
                             input int delay, input axiResp_t exp, input string what);
    axiResp_t resp;
    busWrite(addr, data, strb, delay, resp);
    checkResp(resp, exp, what);
  endtask

  task automatic readExpect(input regAddr_t addr, input word32_t exp, input axiResp_t expResp,
                            input string what);
    word32_t  data;
    axiResp_t resp;
    busRead(addr, randDelay(), data, resp);
    checkResp(resp, expResp, what);
    checkWord(data, exp, what);
  endtask

  task automatic loadJob(input block128_t key, input block128_t pt);
    for (int i = 0; i < 4; i++) begin
      writeExpect(regAddr_t'(`REG_KEY0 + 4*i), key[127-32*i -: 32], 4'hf, randDelay(),
                  RESP_OKAY, "key write");
      writeExpect(regAddr_t'(`REG_PT0 + 4*i), pt[127-32*i -: 32], 4'hf, randDelay(),
                  RESP_OKAY, "plaintext write");
    end
  endtask

  task automatic waitDone();
    word32_t  status;
    axiResp_t resp;
    do begin // poll until the done bit
      busRead(`REG_STATUS, randDelay(), status, resp);
      checkResp(resp, RESP_OKAY, "status poll");
    end while (!status[1]);
    checkWord(status, 32'h2, "status after done");
  endtask

  task automatic readCt(output block128_t ct);
    word32_t  data;
    axiResp_t resp;
    for (int i = 0; i < 4; i++) begin
      busRead(regAddr_t'(`REG_CT0 + 4*i), randDelay(), data, resp);
      checkResp(resp, RESP_OKAY, "ciphertext read");
      ct[127-32*i -: 32] = data;
    end
  endtask

  task automatic checkBusErrors();
    regAddr_t   addr;
    logic [3:0] strb;
    writeExpect(`REG_STATUS, randBits(32), 4'hf, randDelay(), RESP_SLVERR, "status write");
    writeExpect(`REG_CT0, randBits(32), 4'hf, randDelay(), RESP_SLVERR, "ct write");
    writeExpect(6'h08, randBits(32), 4'hf, randDelay(), RESP_SLVERR, "unmapped write");
    do strb = randBits(4); while (strb == 4'hf);
    writeExpect(`REG_KEY0, randBits(32), strb, randDelay(), RESP_SLVERR, "partial strobe");
    readExpect(`REG_KEY0, '0, RESP_SLVERR, "key read");
    readExpect(`REG_PT2, '0, RESP_SLVERR, "plaintext read");
    readExpect(6'h08, '0, RESP_SLVERR, "unmapped read");
    repeat (3) begin // random illegal addresses
      do addr = randBits(6); while (isWritable(addr));
      writeExpect(addr, randBits(32), 4'hf, randDelay(), RESP_SLVERR, "illegal write");
      do addr = randBits(6); while (isReadable(addr));
      readExpect(addr, '0, RESP_SLVERR, "illegal read");
    end
  endtask

  // zero bready delay keeps both writes inside the busy window
  task automatic startWhileBusy(input block128_t key);
    writeExpect(`REG_CTRL, 32'h1, 4'hf, 0, RESP_OKAY, "start");
    writeExpect(`REG_KEY0, ~key[127:96], 4'hf, 0, RESP_SLVERR, "key write while busy");
    writeExpect(`REG_CTRL, 32'h1, 4'hf, 0, RESP_SLVERR, "start while busy");
  endtask

  task automatic holdResult(input block128_t expCt);
    block128_t ct;
    readExpect(`REG_STATUS, 32'h2, RESP_OKAY, "status held");
    readCt(ct);
    checkBlock(ct, expCt, "ciphertext reread");
    writeExpect(`REG_CTRL, 32'h0, 4'hf, randDelay(), RESP_OKAY, "ctrl write without start");
    readExpect(`REG_STATUS, 32'h2, RESP_OKAY, "status after empty ctrl write");
    writeExpect(`REG_CTRL, 32'h1, 4'hf, 0, RESP_OKAY, "restart");
    readExpect(`REG_STATUS, 32'h1, RESP_OKAY, "status after restart"); // busy, done clear
    waitDone();
    readCt(ct);
    checkBlock(ct, expCt, "ciphertext after restart");
  endtask

  initial begin
    block128_t key;
    block128_t pt;
    block128_t expCt;
    block128_t gotCt;
    lfsr  = 32'd43;
    reset = 1'b1;
    wrReq = '0;
    rdReq = '0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    readExpect(`REG_STATUS, '0, RESP_OKAY, "status after reset");
    for (int i = 0; i < 4; i++) begin
      readExpect(regAddr_t'(`REG_CT0 + 4*i), '0, RESP_OKAY, "ct after reset");
    end
    for (int job = 0; job < JOBS; job++) begin
      key   = randBlock();
      pt    = randBlock();
      expCt = aesModel::encrypt(key, pt);
      loadJob(key, pt);
      if (job == 5) checkBusErrors(); // rejected writes must leave key and plaintext intact
      if (job == 10) begin
        startWhileBusy(key);
      end else begin
        writeExpect(`REG_CTRL, 32'h1, 4'hf, randDelay(), RESP_OKAY, "start");
      end
      waitDone();
      readCt(gotCt);
      checkBlock(gotCt, expCt, "ciphertext");
      if (job == 10) holdResult(expCt); // restart reuses the stored key words
    end
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/aesCore_checker.sv
`default_nettype none

module aesCoreChecker (
  input logic              clk,
  input logic              reset,
  input aesPkg::axiWrReq_s wrReq,
  input aesPkg::axiWrRsp_s wrRsp,
  input aesPkg::axiRdReq_s rdReq,
  input aesPkg::axiRdRsp_s rdRsp,
  input logic              busy,
  input logic              start,
  input logic              done
);
  import aesPkg::*;

  // write response held until bready
  assert property (@(posedge clk) disable iff (reset)
    wrRsp.bvalid && !wrReq.bready |=> wrRsp.bvalid && $stable(wrRsp.bresp))
    else $error("bvalid or bresp changed before bready");

  // read response held until rready
  assert property (@(posedge clk) disable iff (reset)
    rdRsp.rvalid && !rdReq.rready |=> rdRsp.rvalid && $stable(rdRsp.rdata) && $stable(rdRsp.rresp))
    else $error("rvalid, rdata or rresp changed before rready");

  assert property (@(posedge clk) disable iff (reset) start |-> ##11 done)
    else $error("done did not follow start by 11 cycles");

  assert property (@(posedge clk) reset |=> !busy)
    else $error("busy high after reset");

endmodule

bind aesCore aesCoreChecker i_aesCoreChecker (
  .clk  (clk),
  .reset(reset),
  .wrReq(wrReq),
  .wrRsp(wrRsp),
  .rdReq(rdReq),
  .rdRsp(rdRsp),
  .busy (busy),
  .start(job.start),
  .done (engDone.done)
);

`default_nettype wire

//--- test/aesModel.sv
`default_nettype none

package aesModel;

  // multiply by x, poly 0x11b
  function automatic logic [7:0] mulX(input logic [7:0] a);
    return a[7] ? ({a[6:0], 1'b0} ^ 8'h1b) : {a[6:0], 1'b0};
  endfunction

  function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    p = 8'h00;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) p = p ^ a; // shift-and-add
      a = mulX(a);
    end
    return p;
  endfunction

  // a^254, which maps 0 to 0
  function automatic logic [7:0] gfInv(input logic [7:0] a);
    logic [7:0] r;
    logic [7:0] base;
    r = 8'h01;
    base = a;
    for (int e = 254; e != 0; e = e >> 1) begin
      if (e[0]) r = gfMul(r, base);
      base = gfMul(base, base);
    end
    return r;
  endfunction

  function automatic logic [7:0] rotl(input logic [7:0] x, input int n);
    return (x << n) | (x >> (8 - n));
  endfunction

  // inverse then affine map
  function automatic logic [7:0] subByte(input logic [7:0] a);
    logic [7:0] x;
    x = gfInv(a);
    return x ^ rotl(x, 1) ^ rotl(x, 2) ^ rotl(x, 3) ^ rotl(x, 4) ^ 8'h63;
  endfunction

  function automatic logic [127:0] encrypt(input logic [127:0] key, input logic [127:0] pt);
    logic [31:0]  w [44];
    logic [7:0]   s [16]; // byte r+4c
    logic [7:0]   t [16];
    logic [7:0]   rc;
    logic [7:0]   a0, a1, a2, a3;
    logic [31:0]  temp;
    logic [127:0] ct;
    rc = 8'h01;
    for (int i = 0; i < 4; i++) w[i] = key[127-32*i -: 32];
    for (int i = 4; i < 44; i++) begin
      temp = w[i-1];
      if (i % 4 == 0) begin
        temp = {subByte(temp[23:16]), subByte(temp[15:8]), subByte(temp[7:0]),
                subByte(temp[31:24])} ^ {rc, 24'h0};
        rc = mulX(rc);
      end
      w[i] = w[i-4] ^ temp;
    end
    for (int i = 0; i < 16; i++) s[i] = pt[127-8*i -: 8] ^ key[127-8*i -: 8];
    for (int rnd = 1; rnd <= 10; rnd++) begin
      for (int i = 0; i < 16; i++) t[i] = subByte(s[i]);
      for (int c = 0; c < 4; c++) begin
        for (int r = 0; r < 4; r++) s[r+4*c] = t[r+4*((c+r)%4)]; // row r left by r
      end
      if (rnd < 10) begin
        for (int c = 0; c < 4; c++) begin
          a0 = s[4*c];
          a1 = s[4*c+1];
          a2 = s[4*c+2];
          a3 = s[4*c+3];
          s[4*c]   = gfMul(a0, 8'h02) ^ gfMul(a1, 8'h03) ^ a2 ^ a3;
          s[4*c+1] = a0 ^ gfMul(a1, 8'h02) ^ gfMul(a2, 8'h03) ^ a3;
          s[4*c+2] = a0 ^ a1 ^ gfMul(a2, 8'h02) ^ gfMul(a3, 8'h03);
          s[4*c+3] = gfMul(a0, 8'h03) ^ a1 ^ a2 ^ gfMul(a3, 8'h02);
        end
      end
      for (int i = 0; i < 16; i++) s[i] = s[i] ^ w[4*rnd + i/4][31-8*(i%4) -: 8];
    end
    for (int i = 0; i < 16; i++) ct[127-8*i -: 8] = s[i];
    return ct;
  endfunction

endpackage

`default_nettype wire

//--- verilog/aesCore.sv
`default_nettype none

module aesCore (
  input  logic              clk,
  input  logic              reset,
  input  aesPkg::axiWrReq_s wrReq,
  output aesPkg::axiWrRsp_s wrRsp,
  input  aesPkg::axiRdReq_s rdReq,
  output aesPkg::axiRdRsp_s rdRsp
);
  import aesPkg::*;

  aesJob_s  job;     // decode to engine
  aesDone_s engDone; // engine to result
  logic     busy;

  aesRegDecode i_aesRegDecode (
    .clk  (clk),
    .reset(reset),
    .wrReq(wrReq),
    .wrRsp(wrRsp),
    .busy (busy),
    .job  (job)
  );

  aesRoundEngine i_aesRoundEngine (
    .clk  (clk),
    .reset(reset),
    .job  (job),
    .done (engDone),
    .busy (busy)
  );

  aesResult i_aesResult (
    .clk    (clk),
    .reset  (reset),
    .rdReq  (rdReq),
    .rdRsp  (rdRsp),
    .busy   (busy),
    .engDone(engDone),
    .start  (job.start) // clears the done bit
  );

endmodule

`default_nettype wire

//--- verilog/aesPkg.sv
`default_nettype none

`include "aes_macros.svh"

package aesPkg;

  typedef logic [7:0]             byte8_t;
  typedef logic [`AXI_DATA_W-1:0] word32_t;
  typedef logic [127:0]           block128_t; // byte 0 in [127:120]
  typedef logic [3:0]             roundIdx_t;
  typedef logic [`AXI_ADDR_W-1:0] regAddr_t;
  typedef logic [1:0]             axiResp_t;

  localparam axiResp_t RESP_OKAY   = 2'b00;
  localparam axiResp_t RESP_SLVERR = 2'b10;

  typedef struct packed {
    regAddr_t                   awaddr;
    logic                       awvalid;
    word32_t                    wdata;
    logic [`AXI_DATA_W/8-1:0]   wstrb;
    logic                       wvalid;
    logic                       bready;
  } axiWrReq_s;

  typedef struct packed {
    logic     awready;
    logic     wready;
    axiResp_t bresp;
    logic     bvalid;
  } axiWrRsp_s;

  typedef struct packed {
    regAddr_t araddr;
    logic     arvalid;
    logic     rready;
  } axiRdReq_s;

  typedef struct packed {
    logic     arready;
    word32_t  rdata;
    axiResp_t rresp;
    logic     rvalid;
  } axiRdRsp_s;

  typedef struct packed {
    logic      start; // one-cycle strobe
    block128_t key;
    block128_t pt;
  } aesJob_s;

  typedef struct packed {
    logic      done; // one-cycle strobe
    block128_t ct;
  } aesDone_s;

  typedef enum logic {ENG_IDLE, ENG_ROUND} engState_e;

  // multiply by x in GF(2^8), poly 0x11b
  function automatic byte8_t xtime(input byte8_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

endpackage

`default_nettype wire

//--- verilog/aesRegDecode.sv
`default_nettype none

`include "aes_macros.svh"

module aesRegDecode (
  input  logic              clk,
  input  logic              reset,
  input  aesPkg::axiWrReq_s wrReq,
  output aesPkg::axiWrRsp_s wrRsp,
  input  logic              busy,
  output aesPkg::aesJob_s   job
);
  import aesPkg::*;

  word32_t  keyWord [4]; // index 0 is KEY0, most significant
  word32_t  ptWord  [4];
  regAddr_t addr;
  logic [1:0] wordSel;
  logic     accept;      // address and data taken this cycle
  logic     aligned;
  logic     fullStrb;
  logic     isCtrl;
  logic     isKey;
  logic     isPt;
  logic     wrOk;
  logic     bvalid;
  axiResp_t bresp;
  logic     start;

  assign addr     = wrReq.awaddr;
  assign wordSel  = addr[3:2];
  assign aligned  = (addr[1:0] == 2'b00);
  assign fullStrb = &wrReq.wstrb; // partial writes are refused

  // both channels together, only with no response outstanding
  assign accept = wrReq.awvalid && wrReq.wvalid && !bvalid;

  assign isCtrl = (addr == `REG_CTRL);
  assign isKey  = aligned && (addr >= `REG_KEY0) && (addr <= `REG_KEY3);
  assign isPt   = aligned && (addr >= `REG_PT0) && (addr <= `REG_PT3);

  // STATUS, CT and holes fall through to SLVERR
  assign wrOk = (isCtrl || isKey || isPt) && fullStrb && !busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      bvalid <= 1'b0;
      start  <= 1'b0;
    end else begin
      start <= accept && wrOk && isCtrl && wrReq.wdata[0]; // rises with bvalid
      if (accept) begin
        bvalid <= 1'b1;
      end else if (wrReq.bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // response code and register contents
  always_ff @(posedge clk) begin
    if (accept) begin
      bresp <= wrOk ? RESP_OKAY : RESP_SLVERR; // held until bready
    end
    if (accept && wrOk && isKey) begin
      keyWord[wordSel] <= wrReq.wdata;
    end
    if (accept && wrOk && isPt) begin
      ptWord[wordSel] <= wrReq.wdata;
    end
  end

  always_comb begin
    wrRsp.awready = accept;
    wrRsp.wready  = accept;
    wrRsp.bresp   = bresp;
    wrRsp.bvalid  = bvalid;
  end

  always_comb begin
    job.start = start;
    job.key   = {keyWord[0], keyWord[1], keyWord[2], keyWord[3]};
    job.pt    = {ptWord[0], ptWord[1], ptWord[2], ptWord[3]};
  end

endmodule

`default_nettype wire

//--- verilog/aesResult.sv
`default_nettype none

`include "aes_macros.svh"

module aesResult (
  input  logic              clk,
  input  logic              reset,
  input  aesPkg::axiRdReq_s rdReq,
  output aesPkg::axiRdRsp_s rdRsp,
  input  logic              busy,
  input  aesPkg::aesDone_s  engDone,
  input  logic              start
);
  import aesPkg::*;

  block128_t ctReg;   // last ciphertext
  logic      doneBit; // set by done, cleared by next start
  logic      accept;
  logic      rvalid;
  word32_t   rdata;
  axiResp_t  rresp;
  word32_t   dataNext;
  axiResp_t  respNext;
  regAddr_t  addr;

  assign addr   = rdReq.araddr;
  assign accept = rdReq.arvalid && !rvalid; // one read in flight

  always_comb begin
    dataNext = '0; // unmapped and KEY/PT reads give 0
    respNext = RESP_SLVERR;
    if (addr == `REG_STATUS) begin
      dataNext = {30'b0, doneBit, busy};
      respNext = RESP_OKAY;
    end else if (addr >= `REG_CT0 && addr <= `REG_CT3 && addr[1:0] == 2'b00) begin
      respNext = RESP_OKAY;
      case (addr[3:2])
        2'd0:    dataNext = ctReg[127:96];
        2'd1:    dataNext = ctReg[95:64];
        2'd2:    dataNext = ctReg[63:32];
        default: dataNext = ctReg[31:0];
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rvalid  <= 1'b0;
      doneBit <= 1'b0;
      ctReg   <= '0; // CT reads 0 before the first job
    end else begin
      if (accept) begin
        rvalid <= 1'b1;
      end else if (rdReq.rready) begin
        rvalid <= 1'b0;
      end
      if (engDone.done) begin
        ctReg   <= engDone.ct;
        doneBit <= 1'b1;
      end else if (start) begin
        doneBit <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rdata <= dataNext; // stable while rvalid waits
      rresp <= respNext;
    end
  end

  always_comb begin
    rdRsp.arready = accept;
    rdRsp.rdata   = rdata;
    rdRsp.rresp   = rresp;
    rdRsp.rvalid  = rvalid;
  end

endmodule

`default_nettype wire

//--- verilog/aesRoundEngine.sv
`default_nettype none

`include "aes_macros.svh"

module aesRoundEngine (
  input  logic             clk,
  input  logic             reset,
  input  aesPkg::aesJob_s  job,
  output aesPkg::aesDone_s done,
  output logic             busy
);
  import aesPkg::*;

  localparam roundIdx_t LAST_ROUND = roundIdx_t'(`AES_ROUNDS);

  engState_e fsm;
  roundIdx_t round;      // round computed this cycle
  block128_t stateReg;   // AES state, ciphertext once done
  logic      doneStrobe;
  logic      lastRound;
  logic      keyLoad;
  logic      keyAdvance;
  block128_t roundKey;
  block128_t shiftBlk;
  block128_t mixBlk;
  block128_t roundOut;
  byte8_t    sb [16];    // SubBytes result, byte 0 first

  // one column of MixColumns
  function automatic word32_t mixColumn(input word32_t col);
    byte8_t a0, a1, a2, a3;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
            xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
  endfunction

  genvar i;
  for (i = 0; i < 16; i++) begin : g_subBytes
    sbox i_sbox (
      .in (stateReg[127-8*i -: 8]),
      .out(sb[i])
    );
  end

  keyExpansion i_keyExpansion (
    .clk      (clk),
    .reset    (reset),
    .load     (keyLoad),
    .advance  (keyAdvance),
    .cipherKey(job.key),
    .roundKey (roundKey)
  );

  assign busy       = (fsm == ENG_ROUND);
  assign lastRound  = (round == LAST_ROUND);
  assign keyLoad    = job.start && (fsm == ENG_IDLE);
  assign keyAdvance = busy && !lastRound; // key 10 is the final one

  always_comb begin
    // ShiftRows: byte (r,c) comes from (r, c+r mod 4), byte index r+4c
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shiftBlk[127-8*(r+4*c) -: 8] = sb[r + 4*((c + r) % 4)];
      end
    end
    for (int c = 0; c < 4; c++) begin
      mixBlk[127-32*c -: 32] = mixColumn(shiftBlk[127-32*c -: 32]);
    end
    roundOut = (lastRound ? shiftBlk : mixBlk) ^ roundKey; // no MixColumns in round 10
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fsm        <= ENG_IDLE;
      round      <= '0;
      doneStrobe <= 1'b0;
    end else begin
      doneStrobe <= 1'b0;
      case (fsm)
        ENG_IDLE: if (job.start) begin
          fsm   <= ENG_ROUND;
          round <= roundIdx_t'(1);
        end
        ENG_ROUND: if (lastRound) begin
          fsm        <= ENG_IDLE; // busy drops with done
          doneStrobe <= 1'b1;
        end else begin
          round <= round + 1'b1;
        end
        default: fsm <= ENG_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (keyLoad) begin
      stateReg <= job.pt ^ job.key; // initial AddRoundKey
    end else if (busy) begin
      stateReg <= roundOut;
    end
  end

  always_comb begin
    done.done = doneStrobe;
    done.ct   = stateReg;
  end

endmodule

`default_nettype wire

//--- verilog/keyExpansion.sv
`default_nettype none

module keyExpansion (
  input  logic              clk,
  input  logic              reset,
  input  logic              load,    // new key, produces round key 1
  input  logic              advance, // step to the next round key
  input  aesPkg::block128_t cipherKey,
  output aesPkg::block128_t roundKey
);
  import aesPkg::*;

  block128_t wBlock;    // last expansion block
  byte8_t    rcon;      // rcon used for the block in wBlock
  block128_t srcBlock;  // block being expanded
  byte8_t    rconUse;
  word32_t   rotWord;
  word32_t   subWord;
  word32_t   temp;
  block128_t nextBlock;

  // expand from the raw key on load, else from the held block
  assign srcBlock = load ? cipherKey : wBlock;
  assign rconUse  = load ? 8'h01 : xtime(rcon); // doubling per step

  assign rotWord = {srcBlock[23:0], srcBlock[31:24]}; // RotWord of w3

  // SubWord, one sbox per byte
  genvar i;
  for (i = 0; i < 4; i++) begin : g_subWord
    sbox i_sbox (
      .in (rotWord[8*i +: 8]),
      .out(subWord[8*i +: 8])
    );
  end

  assign temp = subWord ^ {rconUse, 24'h0};

  // chained word XORs, w0 in the top bits
  assign nextBlock[127:96] = srcBlock[127:96] ^ temp;
  assign nextBlock[95:64]  = srcBlock[95:64]  ^ nextBlock[127:96];
  assign nextBlock[63:32]  = srcBlock[63:32]  ^ nextBlock[95:64];
  assign nextBlock[31:0]   = srcBlock[31:0]   ^ nextBlock[63:32];

  always_ff @(posedge clk) begin
    if (reset) begin
      rcon <= 8'h01;
    end else if (load || advance) begin
      rcon <= rconUse;
    end
  end

  // next round key on load or advance
  always_ff @(posedge clk) begin
    if (load || advance) begin
      wBlock <= nextBlock;
    end
  end

  assign roundKey = wBlock; // round key of the round running now

endmodule

`default_nettype wire

//--- verilog/sbox.sv
`default_nettype none

module sbox (
  input  aesPkg::byte8_t in,
  output aesPkg::byte8_t out
);
  import aesPkg::*;

  // forward S-box, row-major from 0x00
  localparam byte8_t SBOX [256] = '{
    8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
    8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
    8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
    8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
    8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
    8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
    8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
    8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
    8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
    8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
    8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
    8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
    8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
    8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
    8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
    8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
    8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
    8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
    8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
    8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
    8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
    8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
    8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
    8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
    8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
    8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
    8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
    8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
    8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
    8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
    8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
    8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
  };

  assign out = SBOX[in]; // pure lookup, no state

endmodule

`default_nettype wire
